// ==== Bender.yml ====
package:
  name: lau

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lau_pkg.sv
      - verilog/prefix_and.sv
      - verilog/dec.sv
      - verilog/down_counter.sv
      - verilog/lau_wb_regs.sv
      - verilog/lau_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock.sv
      - test/lau_tb.sv

// ==== tb.f ====
+incdir+verilog
verilog/lau_pkg.sv
verilog/prefix_and.sv
verilog/dec.sv
verilog/down_counter.sv
verilog/lau_wb_regs.sv
verilog/lau_top.sv
test/tb_clock.sv
test/lau_tb.sv

// ==== test/lau_golden.txt ====
# Columns: test number, operation (W write, R read), word address (hex), data (hex)
# Data on R lines is the expected read value
1 W 0 0000
1 R 1 ffff
1 W 0 0001
1 R 1 0000
1 W 0 0002
1 R 1 0001
1 W 0 0004
1 R 1 0003
1 W 0 0008
1 R 1 0007
1 W 0 0010
1 R 1 000f
1 W 0 0020
1 R 1 001f
1 W 0 0040
1 R 1 003f
1 W 0 0080
1 R 1 007f
1 W 0 0100
1 R 1 00ff
1 W 0 0200
1 R 1 01ff
1 W 0 0400
1 R 1 03ff
1 W 0 0800
1 R 1 07ff
1 W 0 1000
1 R 1 0fff
1 W 0 2000
1 R 1 1fff
1 W 0 4000
1 R 1 3fff
1 W 0 8000
1 R 1 7fff
1 W 0 ffff
1 R 1 fffe

// ==== test/lau_tb.sv ====
//--------------------------------------------------------------------------
// Testbench for the decrement peripheral
// Wishbone bus tasks, golden file replay, random decrement checks,
// counter and interrupt checks, watchdog
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "lau_params.svh"

module lau_tb import lau_pkg::*; ();

	localparam int    seed        = 82;
	localparam int    n_random    = 64;  // Random decrement operands
	localparam string golden_file = "test/lau_golden.txt";

	logic                  clk;
	logic                  rst_n;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [`LAU_ADR_W-1:0] wb_adr;
	logic [`LAU_WIDTH-1:0] wb_wdat;
	logic [`LAU_WIDTH-1:0] wb_rdat;
	logic                  wb_ack;
	logic                  irq;

	// Golden transactions with one entry per line
	int                    g_test[$];
	logic [7:0]            g_op[$];
	logic [`LAU_ADR_W-1:0] g_adr[$];
	logic [`LAU_WIDTH-1:0] g_dat[$];

	int                    golden_n;
	bit                    loaded;       // Golden file read so watchdog may start
	int                    errors;
	int                    test_errors;  // Errors in the running test
	int                    checks;
	int                    tests_run;
	int                    first_rnd;
	logic [`LAU_WIDTH-1:0] rd;
	logic [`LAU_WIDTH-1:0] op_val;
	logic [`LAU_WIDTH-1:0] exp_val;
	bit                    seen;

	tb_clock #(
		.period    (`LAU_CLK_PERIOD),
		.rst_cycles(8)
	) u_clock (
		.clk  (clk),
		.rst_n(rst_n)
	);

	lau_top dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we  (wb_we),
		.wb_adr (wb_adr),
		.wb_wdat(wb_wdat),
		.wb_rdat(wb_rdat),
		.wb_ack (wb_ack),
		.irq    (irq)
	);

	// One classic cycle held until ack
	// stb drops in the cycle after ack
	task automatic bus_cycle(input logic we, input logic [`LAU_ADR_W-1:0] adr,
			input logic [`LAU_WIDTH-1:0] wdat, output logic [`LAU_WIDTH-1:0] rdat);
		int waited;
		@(posedge clk);
		#2;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = we;
		wb_adr  = adr;
		wb_wdat = wdat;
		waited  = 0;
		do begin
			@(posedge clk);
			#1;  // Ack and data settled past the edge
			waited++;
		end while (wb_ack !== 1'b1 && waited < 16);
		rdat = wb_rdat;
		if (wb_ack !== 1'b1) begin
			$display("bus access to address %0d got no ack within 16 cycles", adr);
			errors++;
			test_errors++;
		end else if (waited != 1) begin
			$display("bus access to address %0d got its ack after %0d cycles instead of one",
				adr, waited);
			errors++;
			test_errors++;
		end
		@(posedge clk);
		#2;
		if (wb_ack !== 1'b0) begin
			$display("ack for address %0d stayed high for more than one cycle", adr);
			errors++;
			test_errors++;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [`LAU_ADR_W-1:0] adr, input logic [`LAU_WIDTH-1:0] wdat);
		logic [`LAU_WIDTH-1:0] unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input logic [`LAU_ADR_W-1:0] adr, output logic [`LAU_WIDTH-1:0] rdat);
		bus_cycle(1'b0, adr, '0, rdat);
	endtask

	task automatic compare(input string what, input logic [`LAU_WIDTH-1:0] expected,
			input logic [`LAU_WIDTH-1:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("error: %s expected %h got %h", what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		if (test_errors == 0)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, test_errors);
		tests_run++;
		test_errors = 0;
	endtask

	// Lines starting with # are skipped
	task automatic load_golden();
		int                    fd;
		int                    n;
		int                    t;
		string                 line;
		logic [7:0]            op;
		logic [`LAU_WIDTH-1:0] adr;
		logic [`LAU_WIDTH-1:0] dat;
		fd = $fopen(golden_file, "r");
		if (fd == 0) begin
			$display("could not open the golden file %s", golden_file);
			errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%d %c %h %h", t, op, adr, dat);
					if (n == 4) begin
						g_test.push_back(t);
						g_op.push_back(op);
						g_adr.push_back(adr[`LAU_ADR_W-1:0]);
						g_dat.push_back(dat);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Polls STATUS bit 0 while the count value stays at or below limit
	task automatic poll_expiry(input logic [`LAU_WIDTH-1:0] limit, output bit flag);
		logic [`LAU_WIDTH-1:0] v;
		int                    n;
		flag = 1'b0;
		n = 0;
		while (!flag && n < 40) begin
			wb_read(STATUS, v);
			if (v[0]) begin
				flag = 1'b1;
			end else begin
				wb_read(COUNT_VALUE, v);
				checks++;
				if (v > limit) begin
					$display("error: COUNT_VALUE expected at most %h got %h", limit, v);
					errors++;
					test_errors++;
				end
			end
			n++;
		end
	endtask

	initial begin
		wb_cyc  = 1'b0;
		wb_stb  = 1'b0;
		wb_we   = 1'b0;
		wb_adr  = '0;
		wb_wdat = '0;
		first_rnd = $urandom(seed);
		load_golden();
		golden_n = g_op.size();
		loaded = 1'b1;
		wait (rst_n === 1'b1);

		// Reset state first
		// DEC_RESULT of a zero operand wraps
		for (int a = 0; a < 8; a++) begin
			wb_read(a, rd);
			exp_val = (a == DEC_RESULT) ? 16'hffff : 16'h0000;
			compare($sformatf("wb_rdat at address %0d after reset", a), exp_val, rd);
		end
		checks++;
		if (irq !== 1'b0) begin
			$display("error: irq expected 0 got %h", irq);
			errors++;
			test_errors++;
		end
		wb_write(OPERAND, 16'h1234);
		wb_read(OPERAND, rd);
		compare("wb_rdat at OPERAND", 16'h1234, rd);
		wb_write(COUNT_LOAD, 16'ha5a5);
		wb_read(COUNT_LOAD, rd);
		compare("wb_rdat at COUNT_LOAD", 16'ha5a5, rd);
		wb_write(COUNT_CTRL, 16'h0002);  // Auto-reload only so the counter stays idle
		wb_read(COUNT_CTRL, rd);
		compare("wb_rdat at COUNT_CTRL", 16'h0002, rd);
		wb_write(COUNT_CTRL, 16'h0000);
		wb_write(3'd6, 16'hffff);  // Unmapped write must not stick
		wb_read(3'd6, rd);
		compare("wb_rdat at address 6", 16'h0000, rd);
		wb_read(3'd7, rd);
		compare("wb_rdat at address 7", 16'h0000, rd);
		finish_test(3, "register readback and reset state");

		// Golden replay with read data as the expected value
		for (int i = 0; i < golden_n; i++) begin
			if (g_op[i] == "W") begin
				wb_write(g_adr[i], g_dat[i]);
			end else begin
				wb_read(g_adr[i], rd);
				compare($sformatf("wb_rdat golden test %0d line %0d", g_test[i], i),
					g_dat[i], rd);
			end
		end
		finish_test(1, "decrement edge values");

		for (int i = 0; i < n_random; i++) begin
			op_val  = 16'($urandom);
			exp_val = op_val - 16'd1;  // Wraps modulo 2**16
			wb_write(OPERAND, op_val);
			wb_read(DEC_RESULT, rd);
			compare($sformatf("wb_rdat DEC_RESULT of %h", op_val), exp_val, rd);
		end
		finish_test(2, "random decrement");

		wb_write(COUNT_CTRL, 16'h0000);
		wb_write(COUNT_LOAD, 16'd10);
		wb_read(COUNT_VALUE, rd);
		compare("wb_rdat COUNT_VALUE after load", 16'd10, rd);
		wb_write(COUNT_CTRL, 16'h0001);
		wb_write(COUNT_CTRL, 16'h0000);
		wb_read(COUNT_VALUE, op_val);
		checks++;
		if (op_val >= 16'd10) begin
			$display("error: COUNT_VALUE expected below 000a got %h", op_val);
			errors++;
			test_errors++;
		end
		wb_read(COUNT_VALUE, rd);
		compare("wb_rdat COUNT_VALUE while disabled", op_val, rd);  // Held
		wb_write(COUNT_LOAD, 16'd10);
		wb_read(COUNT_VALUE, rd);
		compare("wb_rdat COUNT_VALUE after reload", 16'd10, rd);
		finish_test(4, "counter hold and count");

		wb_write(STATUS, 16'h0001);
		wb_write(COUNT_CTRL, 16'h0001);  // Enable without auto-reload
		wb_write(COUNT_LOAD, 16'd5);
		poll_expiry(16'd5, seen);
		if (!seen) begin
			$display("expiry flag never set after loading 5 with the counter enabled");
			errors++;
			test_errors++;
		end
		compare("irq after expiry", 16'd1, {15'd0, irq});
		wb_read(COUNT_VALUE, rd);
		compare("wb_rdat COUNT_VALUE after expiry", 16'd0, rd);
		wb_read(COUNT_VALUE, rd);
		compare("wb_rdat COUNT_VALUE held at zero", 16'd0, rd);
		wb_write(STATUS, 16'h0001);  // Write one to clear
		wb_read(STATUS, rd);
		compare("wb_rdat STATUS after clear", 16'd0, rd);
		compare("irq after clear", 16'd0, {15'd0, irq});
		wb_write(COUNT_CTRL, 16'h0000);
		finish_test(5, "expiry and interrupt");

		wb_write(COUNT_LOAD, 16'd6);
		wb_write(COUNT_CTRL, 16'h0003);  // Enable with auto-reload
		poll_expiry(16'd6, seen);
		if (!seen) begin
			$display("expiry flag never set in auto-reload mode");
			errors++;
			test_errors++;
		end
		wb_write(COUNT_CTRL, 16'h0002);  // Paused so no expiry races the clear
		wb_write(STATUS, 16'h0001);
		wb_read(STATUS, rd);
		compare("wb_rdat STATUS after clear in auto-reload mode", 16'd0, rd);
		compare("irq after clear in auto-reload mode", 16'd0, {15'd0, irq});
		wb_write(COUNT_CTRL, 16'h0003);
		poll_expiry(16'd6, seen);
		if (!seen) begin
			$display("expiry flag did not set again after clearing in auto-reload mode");
			errors++;
			test_errors++;
		end
		wb_write(COUNT_CTRL, 16'h0000);
		wb_write(STATUS, 16'h0001);
		finish_test(6, "auto-reload");

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Ten cycles per golden line or random operand plus margin
	initial begin
		wait (loaded);
		repeat ((golden_n + n_random) * 10 + 200) @(posedge clk);
		$display("timeout, the tests did not finish in the expected number of cycles");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== test/tb_clock.sv ====
//--------------------------------------------------------------------------
// Testbench clock and reset generator
// Free-running clock, active-low reset held for a number of cycles
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module tb_clock #(
	parameter int period     = 20,  // Clock period in ns
	parameter int rst_cycles = 8    // Rising edges with reset low
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Release just after an edge, clear of the DUT sampling point
	initial begin
		rst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// ==== verilog/dec.sv ====
//--------------------------------------------------------------------------
// Parallel-prefix decrementer
// z = a - 1, wrapping from 0 to all ones
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module dec import lau_pkg::*; #(
	parameter int     width = 16,   // Word width
	parameter speed_e speed = FAST  // Prefix structure
) (
	input  logic [width-1:0] a,  // Operand
	output logic [width-1:0] z   // Operand minus one
);

	logic [width-1:0] a_inv;  // Ones where a has zeros
	logic [width-1:0] po;     // All lower bits of a are zero

	assign a_inv = ~a;

	prefix_and #(
		.width(width),
		.speed(speed)
	) u_prefix (
		.pi(a_inv),
		.po(po)
	);

	// Bit 0 always flips, bit i flips when a[i-1:0] is zero
	assign z = a ^ {po[width-2:0], 1'b1};

endmodule

// ==== verilog/down_counter.sv ====
//--------------------------------------------------------------------------
// Loadable down-counter
// Reload register, auto-reload at zero, expiry pulse on the 1 to 0 step
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module down_counter import lau_pkg::*; #(
	parameter int     width = 16,   // Counter width
	parameter speed_e speed = FAST  // Decrementer structure
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [width-1:0] load_val,     // Value taken on a load
	input  logic             load_strobe,  // One-cycle load request
	input  logic             count_en,
	input  logic             auto_reload,  // Restart from reload value at zero
	output logic [width-1:0] count_val,
	output logic             expire        // High while stepping 1 to 0
);

	logic [width-1:0] reload_val;  // Last loaded value
	logic [width-1:0] count_dec;   // count_val minus one

	dec #(
		.width(width),
		.speed(speed)
	) u_dec (
		.a(count_val),
		.z(count_dec)
	);

	assign expire = count_en && (count_val == width'(1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reload_val <= '0;
			count_val  <= '0;
		end else if (load_strobe) begin  // Load beats counting
			reload_val <= load_val;
			count_val  <= load_val;
		end else if (count_en) begin
			if (count_val == '0) begin
				if (auto_reload)
					count_val <= reload_val;  // Else hold at zero
			end else begin
				count_val <= count_dec;
			end
		end
	end

endmodule

// ==== verilog/lau_params.svh ====
//--------------------------------------------------------------------------
// Build constants for the decrement peripheral
// Data width, prefix speed, bus address width, clock period
//--------------------------------------------------------------------------

`ifndef LAU_PARAMS_SVH
`define LAU_PARAMS_SVH

// Data word width in bits
`define LAU_WIDTH 16

// Prefix structure used at the top level
`define LAU_SPEED lau_pkg::FAST

// Word address width on the bus
`define LAU_ADR_W 3

// Clock period in ns
`define LAU_CLK_PERIOD 20

`endif

// ==== verilog/lau_pkg.sv ====
//--------------------------------------------------------------------------
// Shared types for the decrement peripheral
// Prefix structure choice, register word addresses, floor log2 helper
//--------------------------------------------------------------------------

package lau_pkg;

	typedef enum logic [1:0] {
		SLOW   = 2'b00,  // Serial chain
		MEDIUM = 2'b01,  // Brent-Kung
		FAST   = 2'b10   // Sklansky
	} speed_e;

	// Word addresses on the bus
	typedef enum logic [2:0] {
		OPERAND     = 3'd0,
		DEC_RESULT  = 3'd1,
		COUNT_LOAD  = 3'd2,
		COUNT_CTRL  = 3'd3,
		COUNT_VALUE = 3'd4,
		STATUS      = 3'd5
	} reg_addr_e;

	// Floor of log2, n must be positive
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m = m + 1;
			p = p * 2;  // Next power of two
		end
		return m;
	endfunction

endpackage

// ==== verilog/lau_top.sv ====
//--------------------------------------------------------------------------
// Decrement peripheral top level
// Wishbone register file and programmable down-counter
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "lau_params.svh"

module lau_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [`LAU_ADR_W-1:0] wb_adr,
	input  logic [`LAU_WIDTH-1:0] wb_wdat,
	output logic [`LAU_WIDTH-1:0] wb_rdat,
	output logic                  wb_ack,
	output logic                  irq      // Sticky expiry
);

	logic [`LAU_WIDTH-1:0] load_val;
	logic                  load_strobe;
	logic                  count_en;
	logic                  auto_reload;
	logic [`LAU_WIDTH-1:0] count_val;
	logic                  expire;  // Counter to status flag

	lau_wb_regs #(
		.width(`LAU_WIDTH),
		.speed(`LAU_SPEED),
		.adr_w(`LAU_ADR_W)
	) u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_wdat    (wb_wdat),
		.wb_rdat    (wb_rdat),
		.wb_ack     (wb_ack),
		.count_val  (count_val),
		.expire     (expire),
		.load_val   (load_val),
		.load_strobe(load_strobe),
		.count_en   (count_en),
		.auto_reload(auto_reload),
		.irq        (irq)
	);

	down_counter #(
		.width(`LAU_WIDTH),
		.speed(`LAU_SPEED)
	) u_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_val   (load_val),
		.load_strobe(load_strobe),
		.count_en   (count_en),
		.auto_reload(auto_reload),
		.count_val  (count_val),
		.expire     (expire)
	);

endmodule

// ==== verilog/lau_wb_regs.sv ====
//--------------------------------------------------------------------------
// Wishbone classic register file
// Operand and its decrement, counter load and control, sticky status, irq
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module lau_wb_regs import lau_pkg::*; #(
	parameter int     width = 16,   // Data width
	parameter speed_e speed = FAST,  // Operand decrementer structure
	parameter int     adr_w = 3     // Word address width
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  logic [adr_w-1:0] wb_adr,
	input  logic [width-1:0] wb_wdat,
	output logic [width-1:0] wb_rdat,
	output logic             wb_ack,
	input  logic [width-1:0] count_val,    // From the counter
	input  logic             expire,       // Counter expiry pulse
	output logic [width-1:0] load_val,     // COUNT_LOAD register
	output logic             load_strobe,  // Pulse after a COUNT_LOAD write
	output logic             count_en,     // COUNT_CTRL bit 0
	output logic             auto_reload,  // COUNT_CTRL bit 1
	output logic             irq
);

	logic             access;      // New cycle seen, ack not yet given
	logic             wr;
	reg_addr_e        adr;
	logic [width-1:0] operand;
	logic [width-1:0] dec_result;  // operand minus one
	logic             expired;     // Sticky STATUS bit 0

	assign access = wb_cyc & wb_stb & ~wb_ack;
	assign wr     = access & wb_we;
	assign adr    = reg_addr_e'(wb_adr);

	dec #(
		.width(width),
		.speed(speed)
	) u_dec (
		.a(operand),
		.z(dec_result)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack      <= 1'b0;
			load_strobe <= 1'b0;
			operand     <= '0;
			load_val    <= '0;
			count_en    <= 1'b0;
			auto_reload <= 1'b0;
			expired     <= 1'b0;
		end else begin
			wb_ack      <= access;  // Single wait state, one-cycle ack
			load_strobe <= wr && (adr == COUNT_LOAD);
			if (wr) begin
				case (adr)
					OPERAND:    operand  <= wb_wdat;
					COUNT_LOAD: load_val <= wb_wdat;
					COUNT_CTRL: begin
						count_en    <= wb_wdat[0];
						auto_reload <= wb_wdat[1];
					end
					default: ;  // Read-only or unmapped
				endcase
			end
			// Set has priority over write-one-to-clear
			if (expire)
				expired <= 1'b1;
			else if (wr && (adr == STATUS) && wb_wdat[0])
				expired <= 1'b0;
		end
	end

	// Read mux, address held stable by the master until ack
	always_comb begin
		wb_rdat = '0;
		case (adr)
			OPERAND:     wb_rdat = operand;
			DEC_RESULT:  wb_rdat = dec_result;
			COUNT_LOAD:  wb_rdat = load_val;
			COUNT_CTRL:  wb_rdat[1:0] = {auto_reload, count_en};
			COUNT_VALUE: wb_rdat = count_val;
			STATUS:      wb_rdat[0] = expired;
			default:     wb_rdat = '0;  // Unmapped reads as zero
		endcase
	end

	assign irq = expired;

endmodule

// ==== verilog/prefix_and.sv ====
//--------------------------------------------------------------------------
// Prefix AND propagate-lookahead block
// Serial, Brent-Kung and Sklansky structures selected by speed
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module prefix_and import lau_pkg::*; #(
	parameter int     width = 16,   // Word width, 2 or more
	parameter speed_e speed = FAST  // Structure choice
) (
	input  logic [width-1:0] pi,  // Propagate in
	output logic [width-1:0] po   // Bit i is AND of pi[i:0]
);

	localparam int m    = log2floor(width - 1) + 1;  // Tree depth, ceil of log2
	localparam int last = 2 * m - 1;                 // Last Brent-Kung row

	if (speed == FAST) begin : g_sklansky
		logic [m:0][width-1:0] pt;  // One row per level

		assign pt[0] = pi;
		for (genvar l = 1; l <= m; l++) begin : g_level
			for (genvar j = 0; j < width; j++) begin : g_bit
				// Upper half of each 2**l group picks up the lower half's top node
				if ((j % (2 ** l)) >= 2 ** (l - 1)) begin : g_black
					assign pt[l][j] = pt[l-1][j]
						& pt[l-1][(j / 2 ** l) * 2 ** l + 2 ** (l - 1) - 1];
				end else begin : g_white
					assign pt[l][j] = pt[l-1][j];  // Pass through
				end
			end
		end
		assign po = pt[m];

	end else if (speed == MEDIUM) begin : g_brent_kung
		logic [last:0][width-1:0] pt;  // Up rows 0..m, down rows m+1..last

		assign pt[0] = pi;

		// Up-sweep
		// Top node of each 2**l span joins its two halves
		for (genvar l = 1; l <= m; l++) begin : g_up
			for (genvar j = 0; j < width; j++) begin : g_bit
				if (((j + 1) % (2 ** l)) == 0) begin : g_black
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j - 2 ** (l - 1)];
				end else begin : g_white
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		// Down-sweep fills the middle nodes from completed prefixes
		for (genvar l = 1; l < m; l++) begin : g_down
			for (genvar j = 0; j < width; j++) begin : g_bit
				if (j >= 2 ** (m - l)
					&& ((j + 1) % (2 ** (m - l))) == 2 ** (m - l - 1)) begin : g_black
					assign pt[m+l][j] = pt[m+l-1][j] & pt[m+l-1][j - 2 ** (m - l - 1)];
				end else begin : g_white
					assign pt[m+l][j] = pt[m+l-1][j];
				end
			end
		end
		assign po = pt[last];

	end else begin : g_serial
		logic [width-1:0] pt;  // Ripple chain

		assign pt[0] = pi[0];
		for (genvar j = 1; j < width; j++) begin : g_bit
			assign pt[j] = pi[j] & pt[j-1];  // One AND per bit
		end
		assign po = pt;
	end

endmodule
